// File: tb.f
alu_op_pkg.sv
alu_data_pkg.sv
cla_adder.sv
barrel_shifter.sv
shift_add_multiplier.sv
restoring_divider.sv
alu.sv
alu_tb.sv

// File: Makefile
TOP = alu_tb

.PHONY: sim clean

# Build, run, then look for the pass message in the log
sim:
	verilator --binary --assert --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb;
	import alu_op_pkg::*;
	import alu_data_pkg::*;

	// Up to 200 ops of at most 40 cycles each
	localparam int cycle_limit = 200 * 40 + 100;

	logic    clock = 1'b0;
	logic    rst;
	logic    start;
	alu_op_e op;
	word_t   a;
	word_t   b;
	dword_t  result;
	logic    done;
	logic    busy;

	// Model answer and latency of the op in flight
	dword_t  expected;
	int      exp_latency;
	// Monitor bookkeeping
	int      cycle;
	int      accept_cycle;
	logic    in_flight;

	alu_op_e logic_ops [6] = '{OP_NOT, OP_AND, OP_OR, OP_ADD, OP_SUB, OP_NEG};
	alu_op_e shift_ops [6] = '{OP_SHL, OP_SHR, OP_ROL, OP_ROR, OP_SHLA, OP_SHRA};
	word_t   corners [3] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};

	alu DUT (.*);

	always #4 clock = ~clock;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	// Expected 64-bit answer from the opcode rules
	function automatic dword_t model_result(input alu_op_e code, input word_t x, input word_t y);
		int unsigned n;
		dword_t      r;
		n = 32'(y[4:0]);
		case (code)
			OP_NOT:          r = {32'h0, ~x};
			OP_AND:          r = {32'h0, x & y};
			OP_OR:           r = {32'h0, x | y};
			OP_ADD:          r = {32'h0, x + y};
			OP_SUB:          r = {32'h0, x - y};
			OP_NEG:          r = {32'h0, -x};
			OP_SHL, OP_SHLA: r = {32'h0, x << n};
			OP_SHR:          r = {32'h0, x >> n};
			OP_SHRA:         r = {32'h0, $signed(x) >>> n};
			// Shift by 32 gives zero so amount 0 needs no special case
			OP_ROL:          r = {32'h0, (x << n) | (x >> (32 - n))};
			OP_ROR:          r = {32'h0, (x >> n) | (x << (32 - n))};
			OP_MUL:          r = dword_t'(x) * dword_t'(y);
			// Zero divisor gives an all-ones quotient and the dividend as remainder
			OP_DIV:          r = (y == '0) ? {x, 32'hffff_ffff} : {x % y, x / y};
			default:         r = '0;
		endcase
		return r;
	endfunction

	// One request
	// Stray keeps start high a cycle longer while busy
	task automatic run_op(input alu_op_e code, input word_t x, input word_t y, input bit stray);
		int waited;
		start       <= 1'b1;
		op          <= code;
		a           <= x;
		b           <= y;
		expected    <= model_result(code, x, y);
		// 2 for one-cycle ops, 2 + 33 for the iterative units
		exp_latency <= (code == OP_MUL || code == OP_DIV) ? 35 : 2;
		@(posedge clock);
		// Request is latched now so scramble the inputs
		start <= stray;
		op    <= OP_NOT;
		a     <= $urandom;
		b     <= $urandom;
		waited = 0;
		do begin
			@(posedge clock);
			start  <= 1'b0;
			waited = waited + 1;
		end while (!done && waited < 40);
		if (!done)
			report_failure("No done pulse within 40 cycles of an accepted start");
		// Idle cycle between requests
		@(posedge clock);
	endtask

	// Acceptance tracking and run length
	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (rst) begin
			in_flight <= 1'b0;
		end else if (start && !busy) begin
			in_flight    <= 1'b1;
			accept_cycle <= cycle;
		end else if (done) begin
			in_flight <= 1'b0;
		end
		if (cycle >= cycle_limit)
			report_failure("Timeout, the test did not finish in its cycle budget");
	end

	assert property (@(posedge clock) rst |=> (!done && !busy && result == '0))
		else report_failure($sformatf(
			"** Error: after reset done = 0x%0h busy = 0x%0h result = 0x%016h",
			$sampled(done), $sampled(busy), $sampled(result)));
	assert property (@(posedge clock) disable iff (rst) done |-> result == expected)
		else report_failure($sformatf("** Error: result = 0x%016h, expected 0x%016h",
			$sampled(result), $sampled(expected)));
	// Fixed latency counted from the accepting edge
	assert property (@(posedge clock) disable iff (rst) done |-> cycle - accept_cycle == exp_latency)
		else report_failure($sformatf(
			"** Error: cycles from start to done = 0x%0h, expected 0x%0h",
			$sampled(cycle) - $sampled(accept_cycle), $sampled(exp_latency)));
	assert property (@(posedge clock) disable iff (rst) done |=> !done)
		else report_failure("done stayed high for more than one cycle");
	assert property (@(posedge clock) disable iff (rst) done |-> !busy)
		else report_failure("** Error: busy = 0x1 while done = 0x1");
	// Ignored starts must not produce a done
	assert property (@(posedge clock) disable iff (rst) done |-> in_flight)
		else report_failure("done pulsed with no accepted operation in flight");

	initial begin
		void'($urandom(85));
		rst          = 1'b1;
		start        = 1'b0;
		op           = OP_ADD;
		a            = '0;
		b            = '0;
		expected     = '0;
		exp_latency  = 2;
		cycle        = 0;
		accept_cycle = 0;
		repeat (2) @(posedge clock);
		rst <= 1'b0;
		@(posedge clock);
		// Logic and adder ops over every corner pair
		foreach (logic_ops[i])
			foreach (corners[j])
				foreach (corners[k])
					run_op(logic_ops[i], corners[j], corners[k], 1'b0);
		repeat (40) run_op(logic_ops[3'($urandom_range(5, 0))], $urandom, $urandom, 1'b0);
		// Unused opcode gives zero
		run_op(alu_op_e'(5'b10000), $urandom, $urandom, 1'b0);
		// Shifts with amounts 0 and 31, a sign-heavy value and random ones
		foreach (shift_ops[i]) begin
			run_op(shift_ops[i], 32'h8000_0001, 32'd0, 1'b0);
			run_op(shift_ops[i], 32'h8000_0001, 32'd31, 1'b0);
			run_op(shift_ops[i], $urandom, 32'd31, 1'b0);
			repeat (4) run_op(shift_ops[i], $urandom, $urandom, 1'b0);
		end
		// Corner pairs include b = 0 for the divide-by-zero case
		foreach (corners[j])
			foreach (corners[k]) begin
				run_op(OP_MUL, corners[j], corners[k], 1'b0);
				run_op(OP_DIV, corners[j], corners[k], 1'b0);
			end
		repeat (10) begin
			run_op(OP_MUL, $urandom, $urandom, 1'b0);
			run_op(OP_DIV, $urandom, $urandom_range(255, 0), 1'b0);
		end
		// Extra start while busy on both short and iterative ops
		run_op(OP_ADD, $urandom, $urandom, 1'b1);
		run_op(OP_SHRA, 32'hf000_0000, 32'd4, 1'b1);
		run_op(OP_MUL, $urandom, $urandom, 1'b1);
		run_op(OP_DIV, $urandom, 32'd7, 1'b1);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire                          clock,
	input  wire                          rst,
	input  wire                          start,
	input  wire alu_op_pkg::alu_op_e     op,
	input  wire alu_data_pkg::word_t     a,
	input  wire alu_data_pkg::word_t     b,
	output alu_data_pkg::dword_t         result,
	output logic                         done,
	output logic                         busy
);
	import alu_op_pkg::*;
	import alu_data_pkg::*;

	// Control states
	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		WAIT_MUL,
		WAIT_DIV
	} state_e;

	state_e  state;

	// Request latched at acceptance
	alu_op_e op_q;
	word_t   a_q;
	word_t   b_q;

	// Adder hookup
	word_t   add_x;
	word_t   add_y;
	logic    add_sub;
	word_t   add_sum;

	// Shifter hookup
	shamt_t  shift_amount;
	logic    shift_right;
	logic    shift_rotate;
	logic    shift_arith;
	word_t   shift_out;

	// Multiplier hookup
	logic    mul_start;
	logic    mul_done;
	dword_t  mul_product;

	// Divider hookup
	logic    div_start;
	logic    div_done;
	word_t   div_quot;
	word_t   div_rem;

	// Single-cycle result for everything but MUL and DIV
	word_t   exec_word;

	// NEG runs as 0 - a, the others as a op b
	assign add_x   = op_q[op_neg_bit] ? '0 : a_q;
	assign add_y   = op_q[op_neg_bit] ? a_q : b_q;
	assign add_sub = op_q[op_sub_bit];

	// Shift controls straight from the opcode bits
	assign shift_amount = b_q[shamt_w-1:0];
	assign shift_right  = op_q[op_right_bit];
	assign shift_rotate = op_q[op_rot_bit];
	assign shift_arith  = op_q[op_arith_bit];

	cla_adder u_adder (
		.x        (add_x),
		.y        (add_y),
		.subtract (add_sub),
		.sum      (add_sum)
	);

	barrel_shifter u_shifter (
		.value   (a_q),
		.amount  (shift_amount),
		.right   (shift_right),
		.rotate  (shift_rotate),
		.arith   (shift_arith),
		.shifted (shift_out)
	);

	shift_add_multiplier u_mul (
		.clock        (clock),
		.rst          (rst),
		.start        (mul_start),
		.multiplicand (a_q),
		.multiplier   (b_q),
		.product      (mul_product),
		.done         (mul_done)
	);

	restoring_divider u_div (
		.clock     (clock),
		.rst       (rst),
		.start     (div_start),
		.dividend  (a_q),
		.divisor   (b_q),
		.quotient  (div_quot),
		.remainder (div_rem),
		.done      (div_done)
	);

	// Result select for the one-cycle operations
	always_comb begin
		case (op_q)
			OP_NOT:  exec_word = ~a_q;
			OP_AND:  exec_word = a_q & b_q;
			OP_OR:   exec_word = a_q | b_q;
			OP_ADD, OP_SUB, OP_NEG: exec_word = add_sum;
			OP_SHL, OP_SHR, OP_ROL, OP_ROR, OP_SHLA, OP_SHRA: exec_word = shift_out;
			// Unknown opcodes give zero
			default: exec_word = '0;
		endcase
	end

	// Requests are taken only in IDLE
	assign busy = (state != IDLE);

	// Control FSM and result capture
	always_ff @(posedge clock) begin
		if (rst) begin
			state     <= IDLE;
			result    <= '0;
			done      <= 1'b0;
			mul_start <= 1'b0;
			div_start <= 1'b0;
		end else begin
			// Pulses last one cycle
			done      <= 1'b0;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						// Iterative units launch right away
						// Operands are latched by the time they sample start
						case (op)
							OP_MUL: begin
								mul_start <= 1'b1;
								state     <= WAIT_MUL;
							end
							OP_DIV: begin
								div_start <= 1'b1;
								state     <= WAIT_DIV;
							end
							default: state <= EXEC;
						endcase
					end
				end
				EXEC: begin
					// Zero-extend into the upper half
					result <= {word_t'(0), exec_word};
					done   <= 1'b1;
					state  <= IDLE;
				end
				WAIT_MUL: begin
					if (mul_done) begin
						result <= mul_product;
						done   <= 1'b1;
						state  <= IDLE;
					end
				end
				WAIT_DIV: begin
					if (div_done) begin
						// Remainder on top, quotient below
						result <= {div_rem, div_quot};
						done   <= 1'b1;
						state  <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Request capture
	always_ff @(posedge clock) begin
		if (state == IDLE && start) begin
			op_q <= op;
			a_q  <= a;
			b_q  <= b;
		end
	end

endmodule

`default_nettype wire

// File: restoring_divider.sv
`timescale 1ns/1ps
`default_nettype none

module restoring_divider (
	input  wire                      clock,
	input  wire                      rst,
	input  wire                      start,
	input  wire alu_data_pkg::word_t dividend,
	input  wire alu_data_pkg::word_t divisor,
	output alu_data_pkg::word_t      quotient,
	output alu_data_pkg::word_t      remainder,
	output logic                     done
);
	import alu_data_pkg::*;

	// Partial remainder
	word_t             rem;
	// Dividend bits shift out the top, quotient bits shift in below
	word_t             quot;
	// Divisor held for the whole run
	word_t             dvsr;
	// Remainder with the next dividend bit brought down
	logic [word_w:0]   shifted;
	// Trial difference, top bit is the borrow
	logic [word_w+1:0] diff;
	// Iteration count and run flag
	count_t            count;
	logic              running;

	assign shifted = {rem, quot[word_w-1]};
	assign diff    = {1'b0, shifted} - {2'b00, dvsr};

	// Control: same 32 steps as the multiplier
	always_ff @(posedge clock) begin
		if (rst) begin
			running <= 1'b0;
			count   <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				count   <= '0;
			end else if (running) begin
				count <= count + count_t'(1);
				if (count == count_t'(word_w - 1)) begin
					running <= 1'b0;
					done    <= 1'b1;
				end
			end
		end
	end

	// Datapath, one quotient bit per step
	always_ff @(posedge clock) begin
		if (start) begin
			rem  <= '0;
			quot <= dividend;
			dvsr <= divisor;
		end else if (running) begin
			if (!diff[word_w+1]) begin
				// Difference fits below the divisor, keep it
				rem  <= diff[word_w-1:0];
				quot <= {quot[word_w-2:0], 1'b1};
			end else begin
				// Borrow, so restore the shifted remainder
				// Top bit of shifted is zero here
				rem  <= shifted[word_w-1:0];
				quot <= {quot[word_w-2:0], 1'b0};
			end
		end
	end

	// Zero divisor never borrows
	// Quotient ends all ones, remainder ends as the dividend
	assign quotient  = quot;
	assign remainder = rem;

endmodule

`default_nettype wire

// File: shift_add_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier (
	input  wire                      clock,
	input  wire                      rst,
	input  wire                      start,
	input  wire alu_data_pkg::word_t multiplicand,
	input  wire alu_data_pkg::word_t multiplier,
	output alu_data_pkg::dword_t     product,
	output logic                     done
);
	import alu_data_pkg::*;

	// Running sum of partial products
	dword_t acc;
	// Multiplicand, moves left one place per step
	dword_t mcand;
	// Multiplier, low bit picks the next partial product
	word_t  mplier;
	// Iteration count and run flag
	count_t count;
	logic   running;

	// Control: 32 steps after start, then a one-cycle done
	always_ff @(posedge clock) begin
		if (rst) begin
			running <= 1'b0;
			count   <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				count   <= '0;
			end else if (running) begin
				count <= count + count_t'(1);
				// Last step raises done with the final sum
				if (count == count_t'(word_w - 1)) begin
					running <= 1'b0;
					done    <= 1'b1;
				end
			end
		end
	end

	// Datapath
	always_ff @(posedge clock) begin
		if (start) begin
			// Fresh operands, empty accumulator
			acc    <= '0;
			mcand  <= {word_t'(0), multiplicand};
			mplier <= multiplier;
		end else if (running) begin
			// Add this partial product when the multiplier bit is set
			if (mplier[0]) begin
				acc <= acc + mcand;
			end
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	// Held after the last step until the next start
	assign product = acc;

endmodule

`default_nettype wire

// File: barrel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter (
	input  wire alu_data_pkg::word_t  value,
	input  wire alu_data_pkg::shamt_t amount,
	input  wire                       right,
	input  wire                       rotate,
	input  wire                       arith,
	output alu_data_pkg::word_t       shifted
);
	import alu_data_pkg::*;

	// Stage outputs, stage 0 is the input
	word_t stage [shamt_w+1];
	// Fill bit for arithmetic right shifts
	logic  sign;

	assign stage[0] = value;
	// Sign only matters on arithmetic right, left arith fills zeros
	assign sign = arith & right & value[word_w-1];

	// Stage k moves by 2**k when amount bit k is set
	for (genvar k = 0; k < shamt_w; k++) begin : g_stage
		word_t              cur;
		word_t              left_v;
		word_t              right_v;
		logic [2**k-1:0]    fill_l;
		logic [2**k-1:0]    fill_r;

		assign cur = stage[k];

		// Left fill: wrapped top bits on rotate, else zeros
		assign fill_l = rotate ? cur[word_w-1 -: 2**k] : '0;

		// Right fill: wrapped low bits, sign copies, or zeros
		assign fill_r = rotate ? cur[0 +: 2**k] : {(2**k){sign}};

		assign left_v  = {cur[word_w-1-2**k:0], fill_l};
		assign right_v = {fill_r, cur[word_w-1:2**k]};

		// Pass through when this amount bit is clear
		assign stage[k+1] = amount[k] ? (right ? right_v : left_v) : cur;
	end

	assign shifted = stage[shamt_w];

endmodule

`default_nettype wire

// File: cla_adder.sv
`timescale 1ns/1ps
`default_nettype none

module cla_adder (
	input  wire alu_data_pkg::word_t x,
	input  wire alu_data_pkg::word_t y,
	input  wire                      subtract,
	output alu_data_pkg::word_t      sum
);
	import alu_data_pkg::*;

	// Second operand after optional inversion
	word_t y_eff;
	// Bit generate and propagate
	word_t g;
	word_t p;
	// Carry into each bit
	word_t c;
	// Group lookahead terms
	logic [word_w/4-1:0] grp_g;
	logic [word_w/4-1:0] grp_p;
	// Carry into each group, top bit is the carry out
	logic [word_w/4:0]   grp_c;

	// Two's complement subtract: invert y and carry in a one
	assign y_eff    = subtract ? ~y : y;
	assign g        = x & y_eff;
	assign p        = x ^ y_eff;
	assign grp_c[0] = subtract;

	for (genvar gi = 0; gi < word_w / 4; gi++) begin : g_group
		logic [3:0] gg;
		logic [3:0] pp;
		logic       cin;

		assign gg  = g[4*gi +: 4];
		assign pp  = p[4*gi +: 4];
		assign cin = grp_c[gi];

		// First level, carries inside the group
		assign c[4*gi]   = cin;
		assign c[4*gi+1] = gg[0] | (pp[0] & cin);
		assign c[4*gi+2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & cin);
		assign c[4*gi+3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
			| (pp[2] & pp[1] & pp[0] & cin);

		// Group generate and propagate
		assign grp_g[gi] = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
			| (pp[3] & pp[2] & pp[1] & gg[0]);
		assign grp_p[gi] = &pp;

		// Second level chains the group carries
		assign grp_c[gi+1] = grp_g[gi] | (grp_p[gi] & grp_c[gi]);
	end

	assign sum = p ^ c;

endmodule

`default_nettype wire

// File: alu_data_pkg.sv
`default_nettype none

package alu_data_pkg;

	// Operand width
	localparam int word_w = 32;

	// Full result width, product or remainder:quotient
	localparam int dword_w = 2 * word_w;

	// Shift amount width, enough for 0 to 31
	localparam int shamt_w = 5;

	// Operand word
	typedef logic [word_w-1:0] word_t;

	// Double-width result
	typedef logic [dword_w-1:0] dword_t;

	// Shift amount
	typedef logic [shamt_w-1:0] shamt_t;

	// Iteration counter, one bit wider than needed for 31
	typedef logic [$clog2(word_w):0] count_t;

endpackage

`default_nettype wire

// File: alu_op_pkg.sv
`default_nettype none

package alu_op_pkg;

	// Opcode field width
	localparam int op_w = 5;

	// Arithmetic group flags
	// Bit 0 picks subtract, bit 1 picks negate
	localparam int op_sub_bit = 0;
	localparam int op_neg_bit = 1;

	// Shift group flags, laid out as 1 1 arith rot right
	localparam int op_right_bit = 0;
	localparam int op_rot_bit   = 1;
	localparam int op_arith_bit = 2;

	// Operation codes
	typedef enum logic [op_w-1:0] {
		OP_NOT  = 5'b00001,
		OP_AND  = 5'b00010,
		OP_OR   = 5'b00011,
		// Adder group
		OP_ADD  = 5'b00100,
		OP_SUB  = 5'b00101,
		OP_NEG  = 5'b00111,
		// Iterative units
		OP_MUL  = 5'b01000,
		OP_DIV  = 5'b01001,
		// Shifter group
		OP_SHL  = 5'b11000,
		OP_SHR  = 5'b11001,
		OP_ROL  = 5'b11010,
		OP_ROR  = 5'b11011,
		OP_SHLA = 5'b11100,
		OP_SHRA = 5'b11101
	} alu_op_e;

endpackage

`default_nettype wire
